/* build.f */
rtl/scan_pkg.sv
rtl/dpram.sv
rtl/line_writer.sv
rtl/line_reader.sv
rtl/scan_doubler.sv
dv/tb_scan_doubler.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_scan_doubler \
	-f build.f -o sim_scan_doubler
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_scan_doubler)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* dv/tb_scan_doubler.sv */
module tb_scan_doubler;

	localparam int NUM_CASES   = 10;
	localparam int DRAIN_LIMIT = 2 * scan_pkg::LINE_MAX + 64;

	// one row of the line table.
	typedef struct packed {
		logic [15:0] count;
		logic [7:0]  pix_gap;
		logic [15:0] end_gap;
		logic        ovr;
	} line_case_t;

	logic                clock;
	logic                reset;
	scan_pkg::src_beat_t src;
	scan_pkg::vid_out_t  vid;
	logic                overrun;

	line_case_t          cases [NUM_CASES];
	string               names [NUM_CASES];
	scan_pkg::vid_out_t  exp_q [$];
	logic [31:0]         rng;
	int                  errors;
	bit                  stalled;
	string               cur_name;

	scan_doubler uut (
		.clock   (clock),
		.reset   (reset),
		.src     (src),
		.vid     (vid),
		.overrun (overrun)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("mismatch %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic apply_reset();
		reset <= 1'b1;
		src   <= '0;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
	endtask

	// a short line behind a long one lands while the reader is still busy.
	task automatic fill_table();
		names[0] = "one_pixel";
		cases[0] = '{16'd1,   8'd0, 16'd10,  1'b0};
		names[1] = "five_pixels";
		cases[1] = '{16'd5,   8'd2, 16'd20,  1'b0};
		names[2] = "sixty_four";
		cases[2] = '{16'd64,  8'd1, 16'd140, 1'b0};
		names[3] = "empty_line";
		cases[3] = '{16'd0,   8'd0, 16'd10,  1'b0};
		names[4] = "after_empty";
		cases[4] = '{16'd5,   8'd0, 16'd20,  1'b0};
		names[5] = "full_256";
		cases[5] = '{16'd256, 8'd0, 16'd520, 1'b0};
		names[6] = "long_300";
		cases[6] = '{16'd300, 8'd0, 16'd520, 1'b0};
		names[7] = "busy_line";
		cases[7] = '{16'd64,  8'd0, 16'd12,  1'b0};
		names[8] = "overrun_line";
		cases[8] = '{16'd5,   8'd0, 16'd20,  1'b1};
		names[9] = "after_reset";
		cases[9] = '{16'd5,   8'd1, 16'd20,  1'b0};
	endtask

	// sends one line and queues the beats the doubler should produce for it.
	task automatic send_line(input int i);
		logic [scan_pkg::PIX_W-1:0] line_q [$];
		scan_pkg::src_beat_t        beat;
		scan_pkg::vid_out_t         e;
		int                         n;
		n = cases[i].count;
		for (int p = 0; p < n; p++) begin
			rng       = xorshift(rng);
			beat.pix  = 1'b1;
			// without a gap the line end rides on the last pixel.
			beat.eol  = (p == n - 1) && (cases[i].pix_gap == 0);
			beat.data = rng[scan_pkg::PIX_W-1:0];
			@(posedge clock);
			src <= beat;
			if (p < scan_pkg::LINE_MAX) begin
				line_q.push_back(beat.data);
			end
			repeat (cases[i].pix_gap) begin
				@(posedge clock);
				src <= '0;
			end
		end
		if (n == 0 || cases[i].pix_gap != 0) begin
			beat     = '0;
			beat.eol = 1'b1;
			@(posedge clock);
			src <= beat;
		end
		@(posedge clock);
		src <= '0;
		if (!cases[i].ovr) begin
			for (int pass = 0; pass < 2; pass++) begin
				for (int p = 0; p < line_q.size(); p++) begin
					e.valid      = 1'b1;
					e.line_start = (p == 0);
					e.pass       = pass[0];
					e.data       = line_q[p];
					exp_q.push_back(e);
				end
			end
		end
	endtask

	task automatic wait_drain(input string name);
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < DRAIN_LIMIT && !stalled) begin
			@(posedge clock);
			cycles++;
		end
		if (exp_q.size() != 0 && !stalled) begin
			errors++;
			stalled = 1'b1;
			$display("timeout in %s: %0d vid beats never arrived", name, exp_q.size());
		end
	endtask

	////////////////////////////////////////////////////////////
	// output monitor
	////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		if (!reset) begin
			if (vid.valid) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("unexpected vid beat in %s with no line pending", cur_name);
				end else begin
					check(cur_name, exp_q.pop_front(), vid);
				end
			end else begin
				check({cur_name, "_idle_data"}, 0, vid.data);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		reset    = 1'b1;
		src      = '0;
		rng      = 32'hb290;
		errors   = 0;
		stalled  = 1'b0;
		cur_name = "reset";
		fill_table();
		apply_reset();

		// nothing may come out before the first line end.
		repeat (20) begin
			@(negedge clock);
			check("idle_valid", 0, vid.valid);
			check("idle_overrun", 0, overrun);
		end

		for (int i = 0; i < NUM_CASES && !stalled; i++) begin
			if (!cases[i].ovr) begin
				wait_drain(cur_name);
				cur_name = names[i];
			end
			send_line(i);
			repeat (cases[i].end_gap) @(posedge clock);
			if (cases[i].ovr) begin
				wait_drain(names[i]);
				repeat (20) begin
					@(negedge clock);
					check({names[i], "_sticky"}, 1, overrun);
				end
				@(posedge clock);
				apply_reset();
				@(negedge clock);
				check({names[i], "_cleared"}, 0, overrun);
			end else begin
				@(negedge clock);
				check({names[i], "_overrun"}, 0, overrun);
			end
		end
		wait_drain(cur_name);
		repeat (10) @(posedge clock);

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* rtl/scan_doubler.sv */
module scan_doubler (
	input  logic                clock,
	input  logic                reset,
	input  scan_pkg::src_beat_t src,
	output scan_pkg::vid_out_t  vid,
	output logic                overrun
);

	scan_pkg::line_info_t        line_done;
	logic                        wr_en;
	logic [scan_pkg::ADDR_W-1:0] wr_addr;
	logic [scan_pkg::PIX_W-1:0]  wr_data;
	logic                        rd_en;
	logic [scan_pkg::ADDR_W-1:0] rd_addr;
	logic [scan_pkg::PIX_W-1:0]  rd_q;

	line_writer u_writer (
		.clock     (clock),
		.reset     (reset),
		.src       (src),
		.ram_en    (wr_en),
		.ram_addr  (wr_addr),
		.ram_data  (wr_data),
		.line_done (line_done)
	);

	// port a only ever writes, port b only ever reads.
	dpram #(
		.addr_width (scan_pkg::ADDR_W),
		.data_width (scan_pkg::PIX_W)
	) u_line_ram (
		.clock     (clock),
		.address_a (wr_addr),
		.address_b (rd_addr),
		.data_a    (wr_data),
		.data_b    ('0),
		.enable_a  (wr_en),
		.enable_b  (rd_en),
		.wren_a    (1'b1),
		.wren_b    (1'b0),
		.q_a       (),
		.q_b       (rd_q)
	);

	line_reader u_reader (
		.clock     (clock),
		.reset     (reset),
		.line_done (line_done),
		.ram_en    (rd_en),
		.ram_addr  (rd_addr),
		.ram_q     (rd_q),
		.vid       (vid),
		.overrun   (overrun)
	);

endmodule

/* rtl/line_reader.sv */
module line_reader (
	input  logic                        clock,
	input  logic                        reset,
	input  scan_pkg::line_info_t        line_done,
	output logic                        ram_en,
	output logic [scan_pkg::ADDR_W-1:0] ram_addr,
	input  logic [scan_pkg::PIX_W-1:0]  ram_q,
	output scan_pkg::vid_out_t          vid,
	output logic                        overrun
);

	scan_pkg::reader_state_e    state;
	logic                       rd_bank;
	logic [scan_pkg::IDX_W-1:0] idx;
	logic [scan_pkg::IDX_W-1:0] last_idx;
	logic [scan_pkg::IDX_W-1:0] len_m1;
	logic                       at_end;
	logic                       accept;
	logic                       s1_valid;
	logic                       s1_start;
	logic                       s1_pass;

	// the writer never announces an empty line, so a length of 256 wraps to index 255.
	assign len_m1 = line_done.len[scan_pkg::IDX_W-1:0] - 1'b1;
	assign accept = line_done.valid && (state == scan_pkg::RD_IDLE);
	assign at_end = idx == last_idx;

	// addresses go out for every cycle of both passes.
	assign ram_en   = state != scan_pkg::RD_IDLE;
	assign ram_addr = {rd_bank, idx};

	////////////////////////////////////////////////////////////
	// pass sequencer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state   <= scan_pkg::RD_IDLE;
			idx     <= '0;
			overrun <= 1'b0;
		end else begin
			// a line that shows up mid-read is lost and overrun stays set until reset.
			if (line_done.valid && !accept) begin
				overrun <= 1'b1;
			end

			case (state)
				scan_pkg::RD_IDLE: begin
					idx <= '0;
					if (line_done.valid) begin
						state <= scan_pkg::RD_PASS0;
					end
				end
				scan_pkg::RD_PASS0: begin
					if (at_end) begin
						idx   <= '0;
						state <= scan_pkg::RD_PASS1;
					end else begin
						idx <= idx + 1'b1;
					end
				end
				scan_pkg::RD_PASS1: begin
					if (at_end) begin
						idx   <= '0;
						state <= scan_pkg::RD_IDLE;
					end else begin
						idx <= idx + 1'b1;
					end
				end
				default: begin
					state <= scan_pkg::RD_IDLE;
				end
			endcase
		end
	end

	// bank and last index of the line being doubled.
	always_ff @(posedge clock) begin
		if (accept) begin
			rd_bank  <= line_done.bank;
			last_idx <= len_m1;
		end
	end

	////////////////////////////////////////////////////////////
	// output pipeline
	////////////////////////////////////////////////////////////

	// stage one lines up with the RAM read, stage two is the vid register.
	always_ff @(posedge clock) begin
		if (reset) begin
			s1_valid <= 1'b0;
			vid      <= '0;
		end else begin
			s1_valid       <= ram_en;
			vid.valid      <= s1_valid;
			vid.line_start <= s1_valid && s1_start;
			vid.pass       <= s1_valid && s1_pass;
			// cycles without a pixel carry zero data
			vid.data       <= s1_valid ? ram_q : '0;
		end

		s1_start <= idx == '0;
		s1_pass  <= state == scan_pkg::RD_PASS1;
	end

endmodule

/* rtl/line_writer.sv */
module line_writer (
	input  logic                        clock,
	input  logic                        reset,
	input  scan_pkg::src_beat_t         src,
	output logic                        ram_en,
	output logic [scan_pkg::ADDR_W-1:0] ram_addr,
	output logic [scan_pkg::PIX_W-1:0]  ram_data,
	output scan_pkg::line_info_t        line_done
);

	logic                       bank;
	logic [scan_pkg::LEN_W-1:0] count;
	logic                       room;
	logic [scan_pkg::LEN_W-1:0] line_len;
	logic                       line_ok;

	////////////////////////////////////////////////////////////
	// write path
	////////////////////////////////////////////////////////////

	// the counter stops at LINE_MAX, so later pixels are simply not stored.
	assign room = count < scan_pkg::LINE_MAX;

	// pixels go straight into the RAM in the cycle they arrive.
	assign ram_en   = src.pix && room;
	assign ram_addr = {bank, count[scan_pkg::IDX_W-1:0]};
	assign ram_data = src.data;

	// length including a pixel carried on the same beat as the line end.
	assign line_len = ram_en ? count + 1'b1 : count;
	assign line_ok  = src.eol && (line_len != '0);

	////////////////////////////////////////////////////////////
	// line bookkeeping
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			bank            <= 1'b0;
			count           <= '0;
			line_done.valid <= 1'b0;
		end else begin
			line_done.valid <= line_ok;
			if (src.eol) begin
				count <= '0;
				// an empty line leaves the bank alone, nothing was written to it.
				if (line_ok) begin
					bank <= ~bank;
				end
			end else begin
				count <= line_len;
			end
		end

		// bank and length of the line that has just ended.
		line_done.bank <= bank;
		line_done.len  <= line_len;
	end

endmodule

/* rtl/dpram.sv */
module dpram #(
	parameter int addr_width = 9,
	parameter int data_width = 8
) (
	input  logic                  clock,
	input  logic [addr_width-1:0] address_a,
	input  logic [addr_width-1:0] address_b,
	input  logic [data_width-1:0] data_a,
	input  logic [data_width-1:0] data_b,
	input  logic                  enable_a,
	input  logic                  enable_b,
	input  logic                  wren_a,
	input  logic                  wren_b,
	output logic [data_width-1:0] q_a,
	output logic [data_width-1:0] q_b
);

	logic [data_width-1:0] mem [0:(1 << addr_width) - 1];

	// both ports write through one process.
	// on a same-address collision port b lands last and wins.
	always_ff @(posedge clock) begin
		if (enable_a && wren_a) begin
			mem[address_a] <= data_a;
		end
		if (enable_b && wren_b) begin
			mem[address_b] <= data_b;
		end
	end

	// reads are registered and q holds its last value while a port is idle.
	always_ff @(posedge clock) begin
		if (enable_a && !wren_a) begin
			q_a <= mem[address_a];
		end
	end

	always_ff @(posedge clock) begin
		if (enable_b && !wren_b) begin
			q_b <= mem[address_b];
		end
	end

endmodule

/* rtl/scan_pkg.sv */
package scan_pkg;

	////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////

	// one pixel is a plain 8-bit colour index.
	localparam int PIX_W    = 8;
	// index of a pixel within one stored line.
	localparam int IDX_W    = 8;
	// pixels past this count on a line are thrown away.
	localparam int LINE_MAX = 256;
	// a bank bit on top of the pixel index keeps two lines in one RAM.
	localparam int ADDR_W   = 9;
	// a line length runs from 0 to LINE_MAX inclusive.
	localparam int LEN_W    = 9;

	////////////////////////////////////////////////////////////
	// structs and state
	////////////////////////////////////////////////////////////

	// one beat from the 15 kHz source.
	typedef struct packed {
		logic             pix;
		logic             eol;
		logic [PIX_W-1:0] data;
	} src_beat_t;

	// a finished line, handed from the input side to the output side.
	typedef struct packed {
		logic             valid;
		logic             bank;
		logic [LEN_W-1:0] len;
	} line_info_t;

	// one doubled output pixel.
	typedef struct packed {
		logic             valid;
		logic             line_start;
		logic             pass;
		logic [PIX_W-1:0] data;
	} vid_out_t;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_PASS0,
		RD_PASS1
	} reader_state_e;

endpackage
